// ==== fdc_cfg.svh ====
/*
 * Floppy controller Type I configuration
 * Clock rate, step periods, head settle time and verify limits.
 * The short test timings are selected by the test input at run time.
 */
`ifndef FDC_CFG_SVH
`define FDC_CFG_SVH

// Clock cycles per millisecond are kept small for simulation
`define FDC_CLKS_PER_MS 50

// Step pulse periods in ms for rate codes 0 to 3
`define FDC_STEP_MS_0 6
`define FDC_STEP_MS_1 12
`define FDC_STEP_MS_2 20
`define FDC_STEP_MS_3 30
`define FDC_STEP_MS_TEST 2

// Head settle time before an ID search
`define FDC_SETTLE_MS 15
`define FDC_SETTLE_MS_TEST 2

// Index pulses seen during verify before a seek error is flagged
`define FDC_INDEX_LIMIT 5
`define FDC_ID_BYTES 6

`endif

// ==== fdc_cmd_pkg.sv ====
/*
 * Floppy controller command types
 * Command byte, step rate field, status bit positions and the
 * states of the Type I command sequencer.
 */
`default_nettype none

package fdc_cmd_pkg;

	typedef logic [7:0] cmd_byte_t;
	typedef logic [1:0] step_rate_t;
	typedef logic [4:0] ms_count_t;
	typedef logic [7:0] status_t;

	// Opcodes of the Type I group come from command bits 7:5
	typedef enum logic [2:0] {
		OP_RESTORE_SEEK = 3'b000,
		OP_STEP         = 3'b001,
		OP_STEP_IN      = 3'b010,
		OP_STEP_OUT     = 3'b011
	} opcode_t;

	// Bit positions inside the status byte where the upper bits read zero
	localparam int STAT_BUSY      = 0;
	localparam int STAT_INDEX     = 1;
	localparam int STAT_TRACK0    = 2;
	localparam int STAT_CRC_ERR   = 3;
	localparam int STAT_SEEK_ERR  = 4;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_COMPARE,
		ST_COUNT,
		ST_PULSE,
		ST_STEP_WAIT,
		ST_VERIFY,
		ST_SETTLE,
		ST_SEARCH
	} seq_state_t;

endpackage

`default_nettype wire

// ==== fdc_disk_pkg.sv ====
/*
 * Floppy disk format types
 * Track number, ID field bytes and their order, and the CRC word
 * that closes every ID field.
 */
`default_nettype none

package fdc_disk_pkg;

	typedef logic [7:0]  track_t;
	typedef logic [7:0]  id_byte_t;
	typedef logic [15:0] crc16_t;

	// Order of the bytes in an ID field after the address mark
	typedef enum logic [2:0] {
		ID_TRACK,
		ID_SIDE,
		ID_SECTOR,
		ID_LENGTH,
		ID_CRC_HI,
		ID_CRC_LO
	} id_index_t;

endpackage

`default_nettype wire

// ==== fdc_id_reader.sv ====
/*
 * ID field reader
 * Collects the six bytes that follow an ID address mark, runs the
 * CCITT CRC-16 over the mark and the four data bytes and publishes
 * the track number with a valid or a CRC error pulse.
 */
`default_nettype none
`include "fdc_cfg.svh"

module fdc_id_reader import fdc_disk_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  id_byte_t rd_byte,
	input  logic     rd_strobe,
	input  logic     rd_mark,
	output track_t   id_track,
	output logic     id_valid,
	output logic     id_crc_err
);

	localparam id_index_t ID_LAST = id_index_t'(`FDC_ID_BYTES - 1);

	logic      collecting;
	id_index_t idx;
	crc16_t    crc;
	track_t    trk_byte;
	id_byte_t  crc_hi;

	// Bitwise CRC-16 with polynomial 0x1021 and the most significant bit first
	function automatic crc16_t crc_byte(input crc16_t c, input id_byte_t b);
		crc16_t r;
		r = c;
		for (int i = 7; i >= 0; i--) begin
			if (r[15] ^ b[i])
				r = {r[14:0], 1'b0} ^ 16'h1021;
			else
				r = {r[14:0], 1'b0};
		end
		return r;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			collecting <= 1'b0;
			idx        <= ID_TRACK;
			crc        <= '1;
			id_valid   <= 1'b0;
			id_crc_err <= 1'b0;
		end else begin
			id_valid   <= 1'b0;
			id_crc_err <= 1'b0;
			if (rd_strobe) begin
				if (rd_mark) begin
					// A new mark restarts collection even in the middle of a field
					collecting <= 1'b1;
					idx        <= ID_TRACK;
					crc        <= crc_byte(16'hFFFF, 8'hFE);
				end else if (collecting) begin
					// Only track, side, sector and length are covered by the CRC
					if (idx < ID_CRC_HI)
						crc <= crc_byte(crc, rd_byte);
					if (idx == ID_LAST) begin
						collecting <= 1'b0;
						id_valid   <= ({crc_hi, rd_byte} == crc);
						id_crc_err <= ({crc_hi, rd_byte} != crc);
					end else begin
						idx <= id_index_t'(idx + 3'd1);
					end
				end
			end
		end
	end

	// Data bytes are captured here and the track is published with the result pulse
	always_ff @(posedge clk) begin
		if (rd_strobe && !rd_mark && collecting) begin
			case (idx)
				ID_TRACK:  trk_byte <= rd_byte;
				ID_CRC_HI: crc_hi   <= rd_byte;
				ID_CRC_LO: id_track <= trk_byte;
				default: ;
			endcase
		end
	end

	// A result is a single pulse because the next field needs a fresh mark
	a_id_result_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		(id_valid || id_crc_err) |=> !(id_valid || id_crc_err));

endmodule

`default_nettype wire

// ==== fdc_ms_timebase.sv ====
/*
 * Millisecond timebase
 * Divides clk down to a one-cycle enable every CLKS_PER_MS cycles.
 */
`default_nettype none
`include "fdc_cfg.svh"

module fdc_ms_timebase #(
	parameter int CLKS_PER_MS = `FDC_CLKS_PER_MS
) (
	input  logic clk,
	input  logic rst_n,
	output logic ms_tick
);

	// A divide by one still needs a one-bit counter
	localparam int CNT_W = (CLKS_PER_MS > 1) ? $clog2(CLKS_PER_MS) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_MS - 1);

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt     <= '0;
			ms_tick <= 1'b0;
		end else begin
			// Tick on the wrap, so the period is exactly CLKS_PER_MS cycles
			ms_tick <= (cnt == CNT_LAST);
			cnt     <= (cnt == CNT_LAST) ? '0 : cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== fdc_track_reg.sv ====
/*
 * Track register
 * Holds the current track number. The host and the command
 * sequencer may both write it; the sequencer has priority.
 */
`default_nettype none

module fdc_track_reg import fdc_disk_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   host_wr,
	input  track_t host_data,
	input  logic   seq_wr,
	input  track_t seq_data,
	output track_t track
);

	track_t track_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			track_q <= '0;
		end else begin
			// A sequencer write in the same cycle overrides the host
			if (seq_wr)
				track_q <= seq_data;
			else if (host_wr)
				track_q <= host_data;
		end
	end

	assign track = track_q;

endmodule

`default_nettype wire

// ==== fdc_type1_seq.sv ====
/*
 * Type I command sequencer
 * Runs Restore, Seek, Step, Step-in and Step-out. Drives the step,
 * direction and head load lines, keeps the track register in step,
 * optionally verifies the track from the ID fields and builds the
 * status byte.
 */
`default_nettype none
`include "fdc_cfg.svh"

module fdc_type1_seq import fdc_cmd_pkg::*, fdc_disk_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      ms_tick,
	input  logic      force_irq,
	input  logic      test,
	input  logic      cmd_start,
	input  cmd_byte_t cmd,
	input  track_t    data_reg,
	input  track_t    track,
	input  logic      index_n,
	input  logic      trk00_n,
	input  track_t    id_track,
	input  logic      id_valid,
	input  logic      id_crc_err,
	output logic      seq_track_wr,
	output track_t    seq_track_data,
	output status_t   status,
	output logic      intrq,
	output logic      step_n,
	output logic      dir_n,
	output logic      hld
);

	seq_state_t state;
	cmd_byte_t  cmd_q;
	track_t     target;
	ms_count_t  ms_cnt;
	ms_count_t  step_load;
	ms_count_t  settle_load;
	step_rate_t rate;
	logic [2:0] index_cnt;
	logic       index_q;
	logic       index_fall;
	logic       crc_err;
	logic       seek_err;
	logic       is_seek;
	logic       track_upd;

	assign rate       = step_rate_t'(cmd_q[1:0]);
	assign is_seek    = (opcode_t'(cmd_q[7:5]) == OP_RESTORE_SEEK);
	// Restore and Seek always move the register and Step only does so with bit 4
	assign track_upd  = is_seek || cmd_q[4];
	assign index_fall = index_q && !index_n;

	// Counters are loaded with period minus one and end on the tick at zero
	always_comb begin
		if (test) begin
			step_load   = ms_count_t'(`FDC_STEP_MS_TEST - 1);
			settle_load = ms_count_t'(`FDC_SETTLE_MS_TEST - 1);
		end else begin
			settle_load = ms_count_t'(`FDC_SETTLE_MS - 1);
			case (rate)
				2'd0:    step_load = ms_count_t'(`FDC_STEP_MS_0 - 1);
				2'd1:    step_load = ms_count_t'(`FDC_STEP_MS_1 - 1);
				2'd2:    step_load = ms_count_t'(`FDC_STEP_MS_2 - 1);
				default: step_load = ms_count_t'(`FDC_STEP_MS_3 - 1);
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state          <= ST_IDLE;
			cmd_q          <= '0;
			target         <= '0;
			ms_cnt         <= '0;
			index_cnt      <= '0;
			index_q        <= 1'b1;
			crc_err        <= 1'b0;
			seek_err       <= 1'b0;
			seq_track_wr   <= 1'b0;
			seq_track_data <= '0;
			intrq          <= 1'b0;
			step_n         <= 1'b1;
			dir_n          <= 1'b1;
			hld            <= 1'b0;
		end else begin
			intrq        <= 1'b0;
			seq_track_wr <= 1'b0;
			index_q      <= index_n;
			if (force_irq) begin
				// Abort puts the drive lines back to their reset levels
				state    <= ST_IDLE;
				step_n   <= 1'b1;
				dir_n    <= 1'b1;
				hld      <= 1'b0;
				crc_err  <= 1'b0;
				seek_err <= 1'b0;
			end else begin
				case (state)
					ST_IDLE: begin
						// Only Type I commands (bit 7 clear) are taken
						if (cmd_start && !cmd[7]) begin
							cmd_q          <= cmd;
							crc_err        <= 1'b0;
							seek_err       <= 1'b0;
							hld            <= cmd[3];
							seq_track_data <= track;
							case (opcode_t'(cmd[7:5]))
								OP_RESTORE_SEEK: begin
									state <= ST_COMPARE;
									if (cmd[4]) begin
										target <= data_reg;
									end else begin
										// Restore starts from 0xFF so every step is counted down
										target         <= '0;
										seq_track_data <= 8'hFF;
										seq_track_wr   <= 1'b1;
									end
								end
								OP_STEP_IN: begin
									dir_n <= 1'b1;
									state <= cmd[4] ? ST_COUNT : ST_PULSE;
								end
								OP_STEP_OUT: begin
									dir_n <= 1'b0;
									state <= cmd[4] ? ST_COUNT : ST_PULSE;
								end
								default: state <= cmd[4] ? ST_COUNT : ST_PULSE;
							endcase
						end
					end
					ST_COMPARE: begin
						// The working copy is compared as the register write may still be in flight
						if (seq_track_data == target) begin
							state <= ST_VERIFY;
						end else begin
							dir_n <= (target > seq_track_data);
							state <= ST_COUNT;
						end
					end
					ST_COUNT: begin
						seq_track_data <= dir_n ? seq_track_data + 8'd1 : seq_track_data - 8'd1;
						seq_track_wr   <= 1'b1;
						state          <= ST_PULSE;
					end
					ST_PULSE: begin
						// Stop here when the head already sits at track 0 while stepping out
						if (!dir_n && !trk00_n) begin
							if (track_upd) begin
								seq_track_data <= '0;
								seq_track_wr   <= 1'b1;
							end
							state <= ST_VERIFY;
						end else begin
							step_n <= 1'b0;
							ms_cnt <= step_load;
							state  <= ST_STEP_WAIT;
						end
					end
					ST_STEP_WAIT: begin
						if (ms_tick) begin
							if (ms_cnt == '0) begin
								step_n <= 1'b1;
								state  <= is_seek ? ST_COMPARE : ST_VERIFY;
							end else begin
								ms_cnt <= ms_cnt - 1'b1;
							end
						end
					end
					ST_VERIFY: begin
						if (!cmd_q[2]) begin
							intrq <= 1'b1;
							state <= ST_IDLE;
						end else begin
							hld    <= 1'b1;
							ms_cnt <= settle_load;
							state  <= ST_SETTLE;
						end
					end
					ST_SETTLE: begin
						if (ms_tick) begin
							if (ms_cnt == '0) begin
								index_cnt <= '0;
								state     <= ST_SEARCH;
							end else begin
								ms_cnt <= ms_cnt - 1'b1;
							end
						end
					end
					ST_SEARCH: begin
						// A bad ID is noted but the search goes on
						if (id_crc_err)
							crc_err <= 1'b1;
						if (id_valid && id_track == track) begin
							intrq <= 1'b1;
							state <= ST_IDLE;
						end else if (index_fall) begin
							if (index_cnt == 3'(`FDC_INDEX_LIMIT - 1)) begin
								seek_err <= 1'b1;
								intrq    <= 1'b1;
								state    <= ST_IDLE;
							end else begin
								index_cnt <= index_cnt + 3'd1;
							end
						end
					end
					default: state <= ST_IDLE;
				endcase
			end
		end
	end

	always_comb begin
		status                = '0;
		status[STAT_BUSY]     = (state != ST_IDLE);
		status[STAT_INDEX]    = !index_n;
		status[STAT_TRACK0]   = !trk00_n;
		status[STAT_CRC_ERR]  = crc_err;
		status[STAT_SEEK_ERR] = seek_err;
	end

	// A step pulse is only ever issued inside a running command
	a_step_busy: assert property (@(posedge clk) disable iff (!rst_n)
		!step_n |-> status[STAT_BUSY]);

	// The interrupt is a single-cycle pulse per command
	a_intrq_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		intrq |=> !intrq);

	// Track register writes come only from an active command
	a_wr_not_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(state == ST_IDLE) |-> !seq_track_wr);

endmodule

`default_nettype wire

// ==== fdc_type1_top.sv ====
/*
 * Floppy controller Type I block
 * Millisecond timebase, ID field reader, track register and the
 * Type I command sequencer wired to the host and drive ports.
 */
`default_nettype none

module fdc_type1_top import fdc_cmd_pkg::*, fdc_disk_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      cmd_start,
	input  cmd_byte_t cmd,
	input  track_t    data_reg,
	input  logic      host_track_wr,
	input  track_t    host_track_data,
	input  logic      force_irq,
	input  logic      test,
	output status_t   status,
	output logic      intrq,
	output track_t    track,
	output logic      step_n,
	output logic      dir_n,
	output logic      hld,
	input  logic      index_n,
	input  logic      trk00_n,
	input  id_byte_t  rd_byte,
	input  logic      rd_strobe,
	input  logic      rd_mark
);

	logic   ms_tick;
	track_t id_track;
	logic   id_valid;
	logic   id_crc_err;
	logic   seq_track_wr;
	track_t seq_track_data;

	fdc_ms_timebase i_fdc_ms_timebase (
		.clk     (clk),
		.rst_n   (rst_n),
		.ms_tick (ms_tick)
	);

	// Read bytes arrive already framed from the data separator
	fdc_id_reader i_fdc_id_reader (
		.clk        (clk),
		.rst_n      (rst_n),
		.rd_byte    (rd_byte),
		.rd_strobe  (rd_strobe),
		.rd_mark    (rd_mark),
		.id_track   (id_track),
		.id_valid   (id_valid),
		.id_crc_err (id_crc_err)
	);

	fdc_track_reg i_fdc_track_reg (
		.clk       (clk),
		.rst_n     (rst_n),
		.host_wr   (host_track_wr),
		.host_data (host_track_data),
		.seq_wr    (seq_track_wr),
		.seq_data  (seq_track_data),
		.track     (track)
	);

	fdc_type1_seq i_fdc_type1_seq (
		.clk            (clk),
		.rst_n          (rst_n),
		.ms_tick        (ms_tick),
		.force_irq      (force_irq),
		.test           (test),
		.cmd_start      (cmd_start),
		.cmd            (cmd),
		.data_reg       (data_reg),
		.track          (track),
		.index_n        (index_n),
		.trk00_n        (trk00_n),
		.id_track       (id_track),
		.id_valid       (id_valid),
		.id_crc_err     (id_crc_err),
		.seq_track_wr   (seq_track_wr),
		.seq_track_data (seq_track_data),
		.status         (status),
		.intrq          (intrq),
		.step_n         (step_n),
		.dir_n          (dir_n),
		.hld            (hld)
	);

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
fdc_cmd_pkg.sv
fdc_disk_pkg.sv
fdc_ms_timebase.sv
fdc_id_reader.sv
fdc_track_reg.sv
fdc_type1_seq.sv
fdc_type1_top.sv
tb_fdc_type1.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the Type I block testbench with Verilator, runs it and
# decides the result from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f --top-module tb_fdc_type1 -o sim_fdc_type1
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_fdc_type1 > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "Simulator exited with status $run_status"
	exit 1
fi

if grep -q "^Simulation completed successfully$" "$LOG"; then
	echo "Result: pass"
	exit 0
fi
echo "Result: fail"
exit 1

// ==== tb_fdc_type1.sv ====
/*
 * Testbench for the floppy controller Type I block
 * A drive model keeps a physical head position, pulses the index line
 * and sends one ID field after each index pulse. The host side runs
 * Restore, Seek, Step and verify commands and checks the results.
 */
`default_nettype none
`include "fdc_cfg.svh"

module tb_fdc_type1 import fdc_cmd_pkg::*, fdc_disk_pkg::*;;

	localparam int WAIT_LIMIT   = 20000;
	localparam int INDEX_PERIOD = 400;
	localparam int INDEX_LOW    = 4;
	localparam int ID_START     = 10;
	// A step lasts between one and two full ms ticks of the short timing
	localparam int STEP_LO = (`FDC_STEP_MS_TEST - 1) * `FDC_CLKS_PER_MS + 1;
	localparam int STEP_HI = `FDC_STEP_MS_TEST * `FDC_CLKS_PER_MS;

	logic      clk = 1'b0;
	logic      rst_n;
	logic      cmd_start;
	cmd_byte_t cmd;
	track_t    data_reg;
	logic      host_track_wr;
	track_t    host_track_data;
	logic      force_irq;
	logic      test;
	status_t   status;
	logic      intrq;
	track_t    track;
	logic      step_n;
	logic      dir_n;
	logic      hld;
	logic      index_n   = 1'b1;
	logic      trk00_n   = 1'b0;
	id_byte_t  rd_byte   = 8'h00;
	logic      rd_strobe = 1'b0;
	logic      rd_mark   = 1'b0;

	// Drive model state
	int       head        = 0;
	int       head_preset = 0;
	logic     head_preset_en = 1'b0;
	logic     step_q      = 1'b1;
	int       low_len     = 0;
	logic     pulse_cut   = 1'b0;
	int       phase       = 0;
	int       step_count  = 0;
	int       irq_count   = 0;
	int       index_count = 0;
	int       id_seq      = 0;
	logic     id_done     = 1'b0;
	int       track_offset = 0;
	int       corrupt_from = 0;
	int       corrupt_ids  = 0;
	id_byte_t id_bytes [6];

	// Bookkeeping of the host side
	int    seed = 52;
	int    checks, check_errors, assert_errors;
	int    step_base, irq_base, index_base;
	int    steps_taken, irqs_taken, index_taken;
	int    start, target;
	logic  timed_out = 1'b0;
	string timeout_reason;

	fdc_type1_top i_fdc_type1_top (
		.clk             (clk),
		.rst_n           (rst_n),
		.cmd_start       (cmd_start),
		.cmd             (cmd),
		.data_reg        (data_reg),
		.host_track_wr   (host_track_wr),
		.host_track_data (host_track_data),
		.force_irq       (force_irq),
		.test            (test),
		.status          (status),
		.intrq           (intrq),
		.track           (track),
		.step_n          (step_n),
		.dir_n           (dir_n),
		.hld             (hld),
		.index_n         (index_n),
		.trk00_n         (trk00_n),
		.rd_byte         (rd_byte),
		.rd_strobe       (rd_strobe),
		.rd_mark         (rd_mark)
	);

	always #20 clk = ~clk;

	// CCITT CRC-16 update that folds a whole byte into the top of the register
	function automatic crc16_t ccitt_update(input crc16_t c, input id_byte_t d);
		crc16_t r;
		r = c ^ {d, 8'h00};
		repeat (8) r = r[15] ? ((r << 1) ^ 16'h1021) : (r << 1);
		return r;
	endfunction

	function automatic int pick_track(input int lo, input int hi);
		int r;
		r = $random(seed) & 32'h7fff_ffff;
		return lo + (r % (hi - lo + 1));
	endfunction

	always @(posedge clk) begin : drive_model
		int     nh;
		crc16_t crc;
		nh = head;
		step_q <= step_n;
		// The head moves on the falling edge of each step pulse
		if (head_preset_en) begin
			nh = head_preset;
		end else if (step_q && !step_n) begin
			if (dir_n)
				nh = head + 1;
			else if (head > 0)
				nh = head - 1;
			step_count <= step_count + 1;
		end
		head    <= nh;
		trk00_n <= (nh != 0);

		if (!step_n) begin
			low_len <= low_len + 1;
			if (force_irq)
				pulse_cut <= 1'b1;
		end else begin
			low_len   <= 0;
			pulse_cut <= 1'b0;
		end
		// An abort may end a pulse early, so only full pulses are measured
		if (rst_n && step_n && !step_q && !pulse_cut) begin
			assert (low_len >= STEP_LO && low_len <= STEP_HI) else begin
				assert_errors++;
				$display("FAILED step pulse width: expected %0d to %0d cycles, actual %0d",
					STEP_LO, STEP_HI, low_len);
			end
		end
		if (intrq)
			irq_count <= irq_count + 1;

		// An index pulse opens each revolution and one ID field follows it
		phase   <= (phase == INDEX_PERIOD - 1) ? 0 : phase + 1;
		index_n <= (phase >= INDEX_LOW);
		if (phase == 0)
			index_count <= index_count + 1;
		rd_strobe <= 1'b0;
		rd_mark   <= 1'b0;
		id_done   <= 1'b0;
		if (phase == ID_START) begin
			id_bytes[0] = 8'(nh + track_offset);
			id_bytes[1] = 8'h00;
			id_bytes[2] = 8'(id_seq % 9 + 1);
			id_bytes[3] = 8'h02;
			crc = ccitt_update(16'hFFFF, 8'hFE);
			for (int i = 0; i < 4; i++)
				crc = ccitt_update(crc, id_bytes[i]);
			if (id_seq >= corrupt_from && id_seq < corrupt_from + corrupt_ids)
				crc = crc ^ 16'h0100;
			id_bytes[4] = crc[15:8];
			id_bytes[5] = crc[7:0];
			rd_strobe <= 1'b1;
			rd_mark   <= 1'b1;
			rd_byte   <= 8'hFE;
		end else if (phase > ID_START && phase <= ID_START + 12 &&
				(phase - ID_START) % 2 == 0) begin
			rd_strobe <= 1'b1;
			rd_byte   <= id_bytes[(phase - ID_START) / 2 - 1];
		end else if (phase == ID_START + 13) begin
			id_seq  <= id_seq + 1;
			id_done <= 1'b1;
		end
	end

	// The interrupt closes a command that was running the cycle before
	a_irq_ends_cmd: assert property (@(posedge clk) disable iff (!rst_n)
		intrq |-> $past(status[STAT_BUSY])) else begin
		assert_errors++;
		$display("intrq pulsed while no command was running");
	end

	a_dir_steady: assert property (@(posedge clk) disable iff (!rst_n)
		!step_n |-> $stable(dir_n)) else begin
		assert_errors++;
		$display("dir_n changed during a step pulse");
	end

	a_idle_no_step: assert property (@(posedge clk) disable iff (!rst_n)
		!status[STAT_BUSY] |-> step_n) else begin
		assert_errors++;
		$display("step_n was low while the controller was idle");
	end

	a_track0_flag: assert property (@(posedge clk) disable iff (!rst_n)
		status[STAT_TRACK0] == (head == 0)) else begin
		assert_errors++;
		$display("track 0 status bit disagrees with the head position");
	end

	// The index status bit follows the index line of the drive
	a_index_flag: assert property (@(posedge clk) disable iff (!rst_n)
		status[STAT_INDEX] == !index_n) else begin
		assert_errors++;
		$display("index status bit disagrees with the index line");
	end

	task automatic check_val(input string name, input int expected, input int actual);
		checks++;
		assert (expected == actual) else begin
			check_errors++;
			$display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	// Parks the main sequence while the timeout watcher ends the run
	task automatic stall_on_timeout(input string what);
		timeout_reason = what;
		timed_out      = 1'b1;
		forever @(posedge clk);
	endtask

	initial begin
		wait (timed_out);
		$display("Timeout: %s", timeout_reason);
		$display("Simulation failed");
		$finish;
	end

	task automatic wait_intrq();
		logic seen;
		seen = 1'b0;
		for (int t = 0; t < WAIT_LIMIT && !seen; t++) begin
			@(posedge clk);
			seen = intrq;
		end
		if (!seen)
			stall_on_timeout("no intrq at the end of a command");
	endtask

	task automatic wait_steps(input int n);
		logic seen;
		seen = 1'b0;
		for (int t = 0; t < WAIT_LIMIT && !seen; t++) begin
			@(posedge clk);
			seen = (step_count - step_base >= n);
		end
		if (!seen)
			stall_on_timeout("the drive did not receive the expected step pulses");
	endtask

	task automatic wait_id_sent();
		logic seen;
		seen = 1'b0;
		for (int t = 0; t < WAIT_LIMIT && !seen; t++) begin
			@(posedge clk);
			seen = id_done;
		end
		if (!seen)
			stall_on_timeout("the drive model sent no ID field");
	endtask

	// Moves the physical head and loads the track register to match
	task automatic place_head(input int pos);
		@(posedge clk);
		head_preset     <= pos;
		head_preset_en  <= 1'b1;
		host_track_wr   <= 1'b1;
		host_track_data <= 8'(pos);
		@(posedge clk);
		head_preset_en <= 1'b0;
		host_track_wr  <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic issue_cmd(input cmd_byte_t c, input track_t dest);
		@(posedge clk);
		cmd_start  <= 1'b1;
		cmd        <= c;
		data_reg   <= dest;
		step_base  = step_count;
		irq_base   = irq_count;
		index_base = index_count;
		@(posedge clk);
		cmd_start <= 1'b0;
		@(posedge clk);
		check_val("busy after start", 1, int'(status[STAT_BUSY]));
	endtask

	task automatic finish_cmd();
		wait_intrq();
		repeat (2) @(posedge clk);
		steps_taken = step_count - step_base;
		irqs_taken  = irq_count - irq_base;
		index_taken = index_count - index_base;
		check_val("busy after intrq", 0, int'(status[STAT_BUSY]));
		check_val("intrq pulses", 1, irqs_taken);
	endtask

	task automatic run_cmd(input cmd_byte_t c, input track_t dest);
		issue_cmd(c, dest);
		finish_cmd();
	endtask

	initial begin
		cmd_start       = 1'b0;
		cmd             = '0;
		data_reg        = '0;
		host_track_wr   = 1'b0;
		host_track_data = '0;
		force_irq       = 1'b0;
		test            = 1'b1;
		rst_n           = 1'b0;
		checks          = 0;
		check_errors    = 0;
		assert_errors   = 0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		repeat (5) @(posedge clk);

		// Restore steps out until the drive reports track 0
		start = pick_track(1, 40);
		place_head(start);
		run_cmd(8'h00, 8'd0);
		check_val("restore track", 0, int'(track));
		check_val("restore head", 0, head);
		check_val("restore track0 bit", 1, int'(status[STAT_TRACK0]));
		check_val("restore steps", start, steps_taken);

		repeat (3) begin
			start  = pick_track(0, 40);
			target = pick_track(0, 60);
			place_head(start);
			run_cmd(8'h10, 8'(target));
			check_val("seek track", target, int'(track));
			check_val("seek head", target, head);
			check_val("seek steps", (target > start) ? target - start : start - target,
				steps_taken);
		end

		// Single steps with and without the track update bit
		place_head(20);
		run_cmd(8'h50, 8'd0);
		check_val("step-in track", 21, int'(track));
		check_val("step-in head", 21, head);
		run_cmd(8'h70, 8'd0);
		check_val("step-out track", 20, int'(track));
		check_val("step-out head", 20, head);
		run_cmd(8'h40, 8'd0);
		check_val("step-in no update track", 20, int'(track));
		check_val("step-in no update head", 21, head);
		run_cmd(8'h60, 8'd0);
		check_val("step-out no update track", 20, int'(track));
		check_val("step-out no update head", 20, head);

		// Seek with verify against correct IDs
		start  = pick_track(0, 30);
		target = pick_track(0, 30);
		place_head(start);
		run_cmd(8'h14, 8'(target));
		check_val("verify track", target, int'(track));
		check_val("verify head load", 1, int'(hld));
		check_val("verify seek error", 0, int'(status[STAT_SEEK_ERR]));
		check_val("verify crc error", 0, int'(status[STAT_CRC_ERR]));

		// IDs with the wrong track number run into the index limit
		@(posedge clk);
		track_offset <= 3;
		run_cmd(8'h14, track);
		check_val("offset seek error", 1, int'(status[STAT_SEEK_ERR]));
		check_val("offset index limit", 1, int'(index_taken >= `FDC_INDEX_LIMIT));
		@(posedge clk);
		track_offset <= 0;

		// Start right after an ID so both bad IDs fall into the search
		wait_id_sent();
		@(posedge clk);
		corrupt_from <= id_seq;
		corrupt_ids  <= 2;
		run_cmd(8'h14, track);
		check_val("crc error bit", 1, int'(status[STAT_CRC_ERR]));
		check_val("crc seek error", 0, int'(status[STAT_SEEK_ERR]));
		@(posedge clk);
		corrupt_ids <= 0;

		// Host write while idle
		@(posedge clk);
		host_track_wr   <= 1'b1;
		host_track_data <= 8'd33;
		@(posedge clk);
		host_track_wr <= 1'b0;
		repeat (2) @(posedge clk);
		check_val("host track write", 33, int'(track));

		// A Restore issued while a Seek runs is ignored
		place_head(10);
		issue_cmd(8'h10, 8'd30);
		repeat (5) @(posedge clk);
		cmd_start <= 1'b1;
		cmd       <= 8'h00;
		data_reg  <= 8'd0;
		@(posedge clk);
		cmd_start <= 1'b0;
		finish_cmd();
		check_val("busy start ignored track", 30, int'(track));
		check_val("busy start ignored head", 30, head);

		// Abort in the middle of a Seek that loaded the head
		issue_cmd(8'h18, 8'd0);
		check_val("seek head load", 1, int'(hld));
		wait_steps(3);
		@(posedge clk);
		force_irq <= 1'b1;
		@(posedge clk);
		force_irq <= 1'b0;
		repeat (2) @(posedge clk);
		check_val("abort step_n", 1, int'(step_n));
		check_val("abort busy", 0, int'(status[STAT_BUSY]));
		check_val("abort head load", 0, int'(hld));
		repeat (10) @(posedge clk);

		$display("%0d checks, %0d failed checks, %0d failed assertions",
			checks, check_errors, assert_errors);
		if (check_errors == 0 && assert_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
